// File: verilog/norm_cfg.svh
// Shared widths and codes for the div/sqrt normalize-and-round stage
// Mantissa frame is FP32 sized, FP16 values sit in its upper bits
// Exponent input is signed and biased per the selected format
// Only FP32 and FP16 are covered
`ifndef NORM_CFG_SVH
`define NORM_CFG_SVH

// Input datapath widths
`define NORM_MANT_W 28 // Hidden bit, 23 fraction bits, 4 extra low bits
`define NORM_EXP_W  10 // Signed biased exponent

// Fraction field widths
`define NORM_FRAC32 23
`define NORM_FRAC16 10

// Exponent field widths
`define NORM_EXPF32 8
`define NORM_EXPF16 5

// Rounding modes
`define NORM_RM_W   2
`define NORM_RM_RNE 2'd0 // Nearest, ties to even
`define NORM_RM_RTZ 2'd1 // Truncate
`define NORM_RM_RUP 2'd2 // Toward +inf
`define NORM_RM_RDN 2'd3 // Toward -inf

// Canonical quiet NaN fractions, MSB of fraction set
`define NORM_QNAN32_FRAC 23'h40_0000
`define NORM_QNAN16_FRAC 10'h200

`endif

// File: verilog/fp_fmt_pkg.sv
// Result word layouts for FP32 and boxed FP16
// FP16 results live in the low half of a 32-bit word, upper half all ones
// The union lets one result word be read either way
`default_nettype none

`include "norm_cfg.svh"

package fp_fmt_pkg;

  //////////////////////////////////////////////////
  // Formats
  //////////////////////////////////////////////////

  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fmt_e;

  // Single precision, 32 bits
  typedef struct packed {
    logic                      sign;
    logic [`NORM_EXPF32-1:0]   exp;
    logic [`NORM_FRAC32-1:0]   frac;
  } fp32_t;

  // Half precision inside a NaN box, 32 bits
  typedef struct packed {
    logic [15:0]               box;  // All ones for a valid box
    logic                      sign;
    logic [`NORM_EXPF16-1:0]   exp;
    logic [`NORM_FRAC16-1:0]   frac;
  } fp16_boxed_t;

  // One result word, decoded per format
  typedef union packed {
    fp32_t       f32;
    fp16_boxed_t f16;
  } result_u;

endpackage

`default_nettype wire

// File: verilog/fp_op_pkg.sv
// Operation inputs, exception flags and internal stage structs
// Operand classes come from the upstream unpacker, already decoded
// The exponent field is signed, biased for the selected format
// Depends on fp_fmt_pkg, compile that first
`default_nettype none

`include "norm_cfg.svh"

package fp_op_pkg;

  // Operand classes from the unpacker
  typedef struct packed {
    logic nan_a;
    logic nan_b;
    logic inf_a;
    logic inf_b;
    logic zero_a;
    logic zero_b;
  } op_class_t;

  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } op_kind_e;

  // Raw div/sqrt result plus mode bits
  typedef struct packed {
    logic [`NORM_MANT_W-1:0]        mant; // Unrounded, hidden bit at MSB
    logic signed [`NORM_EXP_W-1:0]  exp;
    logic                           sign;
    op_kind_e                       op_kind;
    fp_fmt_pkg::fmt_e               fmt;
    logic                           snan; // Some NaN input was signaling
    logic [`NORM_RM_W-1:0]          rm;
  } norm_in_t;

  // IEEE exception flags, NV at MSB
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  // Special-case verdict, result already packed
  typedef struct packed {
    logic                hit;
    fp_fmt_pkg::result_u result;
    logic                nv;
    logic                dz;
    logic                of;
  } special_t;

  // Normalized significand ready for rounding
  typedef struct packed {
    logic [`NORM_FRAC32:0]    sig;  // Hidden bit at MSB, FP16 uses top 11
    logic [`NORM_EXPF32-1:0]  exp;
    logic [3:0]               tail; // Guard, round, extra, extra|sticky
    logic                     uf;
    logic                     of;
  } norm_out_t;

endpackage

`default_nettype wire

// File: verilog/special_case_sel.sv
// Special-case selector for div/sqrt results
// Purely combinational, priority as in IEEE div/sqrt corner cases
// NaN results are always the positive canonical quiet NaN
// Inf/x for div raises OF here, kept for compatibility with the datapath
`default_nettype none

`include "norm_cfg.svh"

module special_case_sel (
  input  fp_op_pkg::norm_in_t  op,
  input  fp_op_pkg::op_class_t cls,
  output fp_op_pkg::special_t  spec
);

  localparam logic [1:0] K_ZERO = 2'd0;
  localparam logic [1:0] K_INF  = 2'd1;
  localparam logic [1:0] K_NAN  = 2'd2;

  logic       is_div;
  logic       is_sqrt;
  logic [1:0] kind;      // Kind of special word to build
  logic       res_sign;

  // Build a zero, inf or qNaN word in the selected format
  function automatic fp_fmt_pkg::result_u make_word(input fp_fmt_pkg::fmt_e fmt,
                                                    input logic sign,
                                                    input logic [1:0] k);
    fp_fmt_pkg::result_u w;
    w = '0;
    if (fmt == fp_fmt_pkg::FMT_FP16)
    begin
      w.f16.box  = '1;                                  // NaN boxing
      w.f16.sign = sign;
      w.f16.exp  = (k == K_ZERO) ? '0 : '1;
      w.f16.frac = (k == K_NAN) ? `NORM_QNAN16_FRAC : '0;
    end
    else
    begin
      w.f32.sign = sign;
      w.f32.exp  = (k == K_ZERO) ? '0 : '1;
      w.f32.frac = (k == K_NAN) ? `NORM_QNAN32_FRAC : '0;
    end
    return w;
  endfunction

  assign is_div  = (op.op_kind == fp_op_pkg::OP_DIV);
  assign is_sqrt = (op.op_kind == fp_op_pkg::OP_SQRT);

  //////////////////////////////////////////////////
  // Priority chain
  //////////////////////////////////////////////////

  always_comb
  begin
    spec.hit = 1'b1;    // Cleared only in the fall-through case
    spec.nv  = 1'b0;
    spec.dz  = 1'b0;
    spec.of  = 1'b0;
    kind     = K_NAN;
    res_sign = 1'b0;    // NaN is positive
    if (cls.nan_a || cls.nan_b)
      spec.nv = op.snan;                          // Only sNaN signals
    else if (cls.inf_a && is_div && cls.inf_b)
      spec.nv = 1'b1;                             // inf/inf
    else if (cls.inf_a && is_sqrt && op.sign)
      spec.nv = 1'b1;                             // sqrt(-inf)
    else if (cls.inf_a)
    begin
      kind     = K_INF;
      res_sign = op.sign;
      spec.of  = is_div;                          // sqrt(+inf) is exact
    end
    else if (is_div && cls.inf_b)
    begin
      kind     = K_ZERO;                          // x/inf
      res_sign = op.sign;
      spec.of  = 1'b1;
    end
    else if (cls.zero_a)
    begin
      if (is_div && cls.zero_b)
        spec.nv = 1'b1;                           // 0/0
      else
      begin
        kind     = K_ZERO;
        res_sign = op.sign;
      end
    end
    else if (is_div && cls.zero_b)
    begin
      kind     = K_INF;                           // x/0
      res_sign = op.sign;
      spec.dz  = 1'b1;
    end
    else if (is_sqrt && op.sign)
      spec.nv = 1'b1;                             // sqrt of negative
    else
      spec.hit = 1'b0;                            // Regular number path
    spec.result = make_word(op.fmt, res_sign, kind);
  end

  // Upstream flags a signaling NaN only when some operand is a NaN
  always_comb
  begin
    snan_needs_nan: assert (!op.snan || cls.nan_a || cls.nan_b)
      else $error("snan set without a NaN operand");
  end

endmodule

`default_nettype wire

// File: verilog/mant_normalize.sv
// Mantissa normalizer for the div/sqrt result
// Input mantissa has hidden bit at MSB or one below it (0.1xx case)
// Negative exponents produce denormals by right shift, shift clamps at 31
// FP16 keeps its 11 significant bits at the top, lower bits go to the tail
// A zero mantissa with a small exponent gives an exact zero, no UF
`default_nettype none

`include "norm_cfg.svh"

module mant_normalize (
  input  fp_op_pkg::norm_in_t  op,
  output fp_op_pkg::norm_out_t norm
);

  localparam int SIG_W  = `NORM_FRAC32 + 1;          // 24
  localparam int EXT_W  = SIG_W + 4;                 // Significand plus tail
  localparam int DROP16 = `NORM_FRAC32 - `NORM_FRAC16; // Bits below FP16 lsb
  localparam int RS_W   = 2 * `NORM_MANT_W + 8;      // Room for 31-bit shift
  localparam int RS_PAD = RS_W - `NORM_MANT_W;

  logic [`NORM_MANT_W-1:0]       mant;
  logic signed [`NORM_EXP_W-1:0] exp_in;
  logic signed [`NORM_EXP_W-1:0] exp_max;   // All-ones exponent of format
  logic signed [`NORM_EXP_W-1:0] exp_dec;
  logic                          msb;
  logic                          fp16;
  logic [`NORM_EXP_W-1:0]        rs_full;   // 1 - exp, unsigned
  logic [4:0]                    rs_amt;
  logic [RS_W-1:0]               rs_vec;
  logic [EXT_W-1:0]              sig_ext;   // {sig, tail} in FP32 frame
  logic [`NORM_EXPF32-1:0]       exp_n;
  logic                          uf;
  logic                          of;

  assign mant    = op.mant;
  assign exp_in  = op.exp;
  assign msb     = mant[`NORM_MANT_W-1];
  assign fp16    = (op.fmt == fp_fmt_pkg::FMT_FP16);
  assign exp_max = fp16 ? 10'sd31 : 10'sd255;
  assign exp_dec = exp_in - 10'sd1;

  //////////////////////////////////////////////////
  // Denormal right shift
  //////////////////////////////////////////////////

  assign rs_full = 10'd1 - $unsigned(exp_in);
  assign rs_amt  = (rs_full > 10'd31) ? 5'd31 : rs_full[4:0]; // All sticky past 28
  assign rs_vec  = {mant, {RS_PAD{1'b0}}} >> rs_amt;

  always_comb
  begin
    sig_ext = mant;
    exp_n   = exp_in[`NORM_EXPF32-1:0];
    uf      = 1'b0;
    of      = 1'b0;
    if (exp_in == '0)
    begin
      sig_ext = {1'b0, mant[`NORM_MANT_W-1:2], |mant[1:0]}; // >>1, fold lsb
      exp_n   = '0;
      uf      = |mant;
    end
    else if (exp_in == 10'sd1 && !msb)
    begin
      exp_n = '0;                               // 0.1xx at exp 1, denormal
      uf    = |mant;
    end
    else if (exp_in[`NORM_EXP_W-1])             // Negative exponent
    begin
      sig_ext = {rs_vec[RS_W-1 -: EXT_W-1], |rs_vec[RS_W-EXT_W:0]};
      exp_n   = '0;
      uf      = |mant;
    end
    else if (exp_in > exp_max || (exp_in == exp_max && msb))
    begin
      sig_ext = '0;                             // Overflow, inf forced later
      exp_n   = '1;
      of      = 1'b1;
    end
    else if (!msb)
    begin
      sig_ext = {mant[`NORM_MANT_W-2:0], 1'b0}; // 0.1xx, shift up
      exp_n   = exp_dec[`NORM_EXPF32-1:0];
    end
  end

  //////////////////////////////////////////////////
  // Format alignment
  //////////////////////////////////////////////////

  always_comb
  begin
    norm.exp = exp_n;
    norm.uf  = uf;
    norm.of  = of;
    if (fp16)
    begin
      norm.sig  = {sig_ext[EXT_W-1 -: SIG_W-DROP16], {DROP16{1'b0}}};
      norm.tail = {sig_ext[EXT_W-SIG_W+DROP16-1 -: 3],
                   |sig_ext[EXT_W-SIG_W+DROP16-4:0]}; // Rest is sticky
    end
    else
    begin
      norm.sig  = sig_ext[EXT_W-1:4];
      norm.tail = sig_ext[3:0];
    end
  end

  // Overflow and underflow are exclusive verdicts
  always_comb
  begin
    of_uf_excl: assert (!(norm.of && norm.uf))
      else $error("normalizer flagged both OF and UF");
  end

endmodule

`default_nettype wire

// File: verilog/round_pack.sv
// Rounder, packer and output register
// Rounding overflow to the all-ones exponent gives infinity in every mode
// Denormals rounding up into the hidden bit become the smallest normal
// Data registers hold their value while in_valid is low
// Special-case verdicts override the rounded result and flags
`default_nettype none

`include "norm_cfg.svh"

module round_pack (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  fp_op_pkg::special_t     spec,
  input  fp_op_pkg::norm_out_t    norm,
  input  logic [`NORM_RM_W-1:0]   rm,
  input  fp_fmt_pkg::fmt_e        fmt,
  input  logic                    sign,
  output logic                    out_valid,
  output fp_fmt_pkg::result_u     out_result,
  output fp_op_pkg::fflags_t      out_flags
);

  localparam int SIG_W  = `NORM_FRAC32 + 1;
  localparam int DROP16 = `NORM_FRAC32 - `NORM_FRAC16;

  logic                      fp16;
  logic                      lsb;
  logic                      guard;
  logic                      sticky;
  logic                      inexact;   // Any dropped bit set
  logic                      round_up;
  logic [SIG_W:0]            sig_inc;
  logic [SIG_W:0]            sig_sum;
  logic                      carry;
  logic                      denorm_up; // Denormal rounded into normal range
  logic [SIG_W-1:0]          sig_r;
  logic [`NORM_EXPF32:0]     exp_r;
  logic [`NORM_EXPF32:0]     exp_ones;
  logic                      ovf;
  fp_fmt_pkg::result_u       res_d;
  fp_op_pkg::fflags_t        flags_d;

  assign fp16     = (fmt == fp_fmt_pkg::FMT_FP16);
  assign exp_ones = fp16 ? 9'd31 : 9'd255;

  //////////////////////////////////////////////////
  // Rounding decision
  //////////////////////////////////////////////////

  assign lsb     = fp16 ? norm.sig[DROP16] : norm.sig[0];
  assign guard   = norm.tail[3];
  assign sticky  = |norm.tail[2:0];
  assign inexact = |norm.tail;

  always_comb
  begin
    case (rm)
      `NORM_RM_RNE: round_up = guard && (sticky || lsb); // Ties to even
      `NORM_RM_RTZ: round_up = 1'b0;
      `NORM_RM_RUP: round_up = inexact && !sign;
      `NORM_RM_RDN: round_up = inexact && sign;
      default:      round_up = 1'b0;
    endcase
  end

  // Increment at the lsb of the selected format
  assign sig_inc   = fp16 ? ((SIG_W+1)'(1) << DROP16) : (SIG_W+1)'(1);
  assign sig_sum   = {1'b0, norm.sig} + (round_up ? sig_inc : '0);
  assign carry     = sig_sum[SIG_W];
  assign sig_r     = carry ? sig_sum[SIG_W:1] : sig_sum[SIG_W-1:0];
  assign denorm_up = (norm.exp == '0) && sig_sum[SIG_W-1];
  assign exp_r     = {1'b0, norm.exp} + {8'd0, carry} + {8'd0, denorm_up};
  assign ovf       = norm.of || (exp_r >= exp_ones);

  //////////////////////////////////////////////////
  // Packing and flags
  //////////////////////////////////////////////////

  always_comb
  begin
    res_d = '0;
    if (fp16)
    begin
      res_d.f16.box  = '1;                               // NaN box
      res_d.f16.sign = sign;
      res_d.f16.exp  = ovf ? '1 : exp_r[`NORM_EXPF16-1:0];
      res_d.f16.frac = ovf ? '0 : sig_r[SIG_W-2 -: `NORM_FRAC16];
    end
    else
    begin
      res_d.f32.sign = sign;
      res_d.f32.exp  = ovf ? '1 : exp_r[`NORM_EXPF32-1:0];
      res_d.f32.frac = ovf ? '0 : sig_r[`NORM_FRAC32-1:0];
    end
    flags_d.nv = 1'b0;
    flags_d.dz = 1'b0;
    flags_d.of = ovf;
    flags_d.uf = norm.uf;
    flags_d.nx = inexact || ovf || norm.uf;
    if (spec.hit)
    begin
      res_d      = spec.result;                          // Special wins
      flags_d.nv = spec.nv;
      flags_d.dz = spec.dz;
      flags_d.of = spec.of;
      flags_d.uf = 1'b0;
      flags_d.nx = spec.of;                              // OF implies NX
    end
  end

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid  <= 1'b0;
      out_result <= '0;
      out_flags  <= '0;
    end
    else
    begin
      out_valid <= in_valid;
      if (in_valid)
      begin
        out_result <= res_d;
        out_flags  <= flags_d;
      end
    end
  end

  // A result never appears without an accepted item the cycle before
  valid_follows_in: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(out_valid) |-> $past(in_valid))
    else $error("out_valid rose without in_valid one cycle earlier");

endmodule

`default_nettype wire

// File: verilog/norm_round_top.sv
// Normalize-and-round stage for an iterative FP div/sqrt unit
// One register stage, one item per cycle, no back-pressure
// Result appears exactly one clock after in_valid is sampled high
// FP32 and FP16 only, FP16 results NaN boxed to 32 bits
`default_nettype none

module norm_round_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  fp_op_pkg::norm_in_t   in_op,
  input  fp_op_pkg::op_class_t  in_class,
  output logic                  out_valid,
  output fp_fmt_pkg::result_u   out_result,
  output fp_op_pkg::fflags_t    out_flags
);

  fp_op_pkg::special_t  spec; // Special-case verdict
  fp_op_pkg::norm_out_t norm; // Aligned significand and exponent

  special_case_sel u_special (
    .op   (in_op),
    .cls  (in_class),
    .spec (spec)
  );

  mant_normalize u_norm (
    .op   (in_op),
    .norm (norm)
  );

  // Rounds, picks special or numeric result, registers outputs
  round_pack u_round (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .spec       (spec),
    .norm       (norm),
    .rm         (in_op.rm),
    .fmt        (in_op.fmt),
    .sign       (in_op.sign),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_flags  (out_flags)
  );

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
// Free-running testbench clock, starts low
// Half period in ns, default gives the 4 ns period
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_NS = 2
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk; // First rising edge at HALF_NS
  end

endmodule

`default_nettype wire

// File: verif/tb_norm_round.sv
// Random testbench for the div/sqrt normalize-and-round stage
// Inputs change on the falling edge, outputs are sampled there too
// Expected values come from a reference model of the stage rules
// Stops at the first wrong value, snan only ever set with a NaN class
`default_nettype none

`include "norm_cfg.svh"

module tb_norm_round;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_ITEMS   = 2000;                          // Valid items to send
  localparam int PERIOD_NS = 4;
  localparam int LIMIT_NS  = 2 * N_ITEMS * PERIOD_NS + 400; // Idle cycles plus margin

  logic                   clk;
  logic                   rst_n;
  logic                   in_valid;
  fp_op_pkg::norm_in_t    in_op;
  fp_op_pkg::op_class_t   in_class;
  logic                   out_valid;
  fp_fmt_pkg::result_u    out_result;
  fp_op_pkg::fflags_t     out_flags;

  integer      seed;
  logic        prev_valid;  // in_valid driven one cycle earlier
  int          sent;
  int          seen;
  logic [37:0] expect_q[$]; // {fp16, result, flags}, at most one deep
  logic [36:0] held;        // Last result and flags, kept while idle

  tb_clk_gen #(.HALF_NS(PERIOD_NS / 2)) u_clk (.clk(clk));

  norm_round_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_class   (in_class),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_flags  (out_flags)
  );

  //////////////////////////////////////////////////
  // Random helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    return int'(rand_word() % 32'(n));
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Right shift, every lost bit ORed into the new lsb
  function automatic logic [27:0] sticky_shift(input logic [27:0] v, input int sh);
    logic [27:0] x;
    logic        lost;
    x    = v;
    lost = 1'b0;
    for (int i = 0; i < sh && i < 40; i++)
    begin
      lost = lost | x[0];
      x    = x >> 1;
    end
    x[0] = x[0] | lost;
    return x;
  endfunction

  // Special-case priority, returns {hit, word, flags}
  function automatic logic [37:0] special_expect(input fp_op_pkg::norm_in_t op,
                                                 input fp_op_pkg::op_class_t cls);
    logic        is_div;
    logic        hit;
    logic        sgn;
    logic        nv;
    logic        dz;
    logic        of;
    int          kind;  // 0 zero, 1 inf, 2 qNaN
    logic [31:0] word;
    is_div = (op.op_kind == fp_op_pkg::OP_DIV);
    hit    = 1'b1;
    kind   = 2;
    sgn    = 1'b0;
    nv     = 1'b0;
    dz     = 1'b0;
    of     = 1'b0;
    if (cls.nan_a || cls.nan_b)
      nv = op.snan;
    else if (cls.inf_a && is_div && cls.inf_b)
      nv = 1'b1;                              // inf/inf
    else if (cls.inf_a && !is_div && op.sign)
      nv = 1'b1;                              // sqrt(-inf)
    else if (cls.inf_a)
    begin
      kind = 1;
      sgn  = op.sign;
      of   = is_div;
    end
    else if (is_div && cls.inf_b)
    begin
      kind = 0;                               // x/inf
      sgn  = op.sign;
      of   = 1'b1;
    end
    else if (cls.zero_a)
    begin
      if (is_div && cls.zero_b)
        nv = 1'b1;                            // 0/0
      else
      begin
        kind = 0;
        sgn  = op.sign;
      end
    end
    else if (is_div && cls.zero_b)
    begin
      kind = 1;                               // x/0
      sgn  = op.sign;
      dz   = 1'b1;
    end
    else if (!is_div && op.sign)
      nv = 1'b1;                              // sqrt of negative
    else
      hit = 1'b0;
    if (op.fmt == fp_fmt_pkg::FMT_FP16)
      word = {16'hffff, sgn, (kind == 0) ? 5'h00 : 5'h1f, (kind == 2) ? 10'h200 : 10'h000};
    else
      word = {sgn, (kind == 0) ? 8'h00 : 8'hff, (kind == 2) ? 23'h40_0000 : 23'h0};
    return {hit, word, nv, dz, of, 1'b0, of};
  endfunction

  // Normalize, round and pack a regular number, returns {word, flags}
  function automatic logic [36:0] numeric_expect(input fp_op_pkg::norm_in_t op);
    logic        fp16;
    int          e;
    int          e_n;
    int          emax;   // All-ones exponent of the format
    int          kb;     // Kept significand bits
    int          drop;
    logic [27:0] ext;
    logic [27:0] low_mask;
    logic [24:0] kept;
    logic        uf;
    logic        of;
    logic        guard;
    logic        rest;
    logic        inexact;
    logic        up;
    logic        ovf;
    logic [31:0] word;
    fp16 = (op.fmt == fp_fmt_pkg::FMT_FP16);
    e    = int'(op.exp);
    emax = fp16 ? 31 : 255;
    kb   = fp16 ? 11 : 24;
    ext  = op.mant;
    e_n  = 0;
    uf   = 1'b0;
    of   = 1'b0;
    if (e == 0)
    begin
      ext = sticky_shift(op.mant, 1);
      uf  = |op.mant;
    end
    else if (e == 1 && !op.mant[27])
      uf = |op.mant;                         // Already a denormal
    else if (e < 0)
    begin
      ext = sticky_shift(op.mant, 1 - e);
      uf  = |op.mant;
    end
    else if (e > emax || (e == emax && op.mant[27]))
      of = 1'b1;
    else if (!op.mant[27])
    begin
      ext = op.mant << 1;
      e_n = e - 1;
    end
    else
      e_n = e;
    drop     = 28 - kb;
    kept     = 25'(ext >> drop);
    guard    = ext[drop-1];
    low_mask = (28'd1 << (drop - 1)) - 28'd1;
    rest     = |(ext & low_mask);
    inexact  = guard || rest;
    case (op.rm)
      `NORM_RM_RNE: up = guard && (rest || kept[0]);
      `NORM_RM_RUP: up = inexact && !op.sign;
      `NORM_RM_RDN: up = inexact && op.sign;
      default:      up = 1'b0;              // Truncate
    endcase
    kept = kept + 25'(up);
    if (kept[kb])
    begin
      kept = kept >> 1;                     // Carry out, bump exponent
      e_n  = e_n + 1;
    end
    else if (e_n == 0 && kept[kb-1])
      e_n = 1;                              // Denormal rounded to smallest normal
    ovf = of || (e_n >= emax);
    if (fp16)
      word = {16'hffff, op.sign, ovf ? 5'h1f : 5'(e_n), ovf ? 10'h0 : kept[9:0]};
    else
      word = {op.sign, ovf ? 8'hff : 8'(e_n), ovf ? 23'h0 : kept[22:0]};
    return {word, 1'b0, 1'b0, ovf, uf, inexact || ovf || uf};
  endfunction

  function automatic logic [37:0] expect_item(input fp_op_pkg::norm_in_t op,
                                              input fp_op_pkg::op_class_t cls);
    logic [37:0] sp;
    logic        fp16;
    sp   = special_expect(op, cls);
    fp16 = (op.fmt == fp_fmt_pkg::FMT_FP16);
    if (sp[37])
      return {fp16, sp[36:0]};
    else
      return {fp16, numeric_expect(op)};
  endfunction

  //////////////////////////////////////////////////
  // Checking and stimulus
  //////////////////////////////////////////////////

  task automatic check_equal(input logic [63:0] got, input logic [63:0] want,
                             input string what);
    if (got !== want)
    begin
      $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, want);
      $display("ERRORS FOUND");
      $fatal(1, "stopping at first error");
    end
  endtask

  // Outputs here belong to the item driven one cycle ago
  task automatic compare_outputs();
    logic [37:0] want;
    check_equal(64'(out_valid), 64'(prev_valid), "out_valid one cycle after in_valid");
    if (out_valid)
    begin
      want = expect_q.pop_front();
      if (want[37])
        check_equal(64'(out_result.f16.box), 64'hffff, "fp16 box");
      check_equal(64'(out_result), 64'(want[36:5]), "result word");
      check_equal(64'(out_flags), 64'(want[4:0]), "flags nv dz of uf nx");
      held = want[36:0];
      seen++;
    end
    else
    begin
      check_equal(64'(out_result), 64'(held[36:5]), "result held while idle");
      check_equal(64'(out_flags), 64'(held[4:0]), "flags held while idle");
    end
  endtask

  // One random item, biased toward corners
  task automatic gen_item(output fp_op_pkg::norm_in_t op,
                          output fp_op_pkg::op_class_t cls);
    int          emax;
    int          pick;
    logic [31:0] r;
    op         = '0;
    cls        = '0;
    r          = rand_word();
    op.sign    = r[0];
    op.op_kind = r[1] ? fp_op_pkg::OP_SQRT : fp_op_pkg::OP_DIV;
    op.fmt     = r[2] ? fp_fmt_pkg::FMT_FP16 : fp_fmt_pkg::FMT_FP32;
    op.rm      = r[4:3];
    emax       = r[2] ? 31 : 255;
    pick = rand_below(10);                   // Mostly a regular number
    if (pick == 0)
      cls = 6'(rand_word());
    else if (pick < 3)
      cls = 6'(6'd1 << rand_below(6));
    if ((cls.nan_a || cls.nan_b) && r[5])
      op.snan = 1'b1;
    pick = rand_below(10);
    case (pick)
      0:       op.exp = 10'sd0;
      1:       op.exp = 10'sd1;
      2:       op.exp = 10'(-1 - rand_below(12));    // Shallow denormals
      3:       op.exp = 10'(-13 - rand_below(40));   // Deep, mostly sticky
      4:       op.exp = 10'(emax - 1 + rand_below(3));
      5:       op.exp = 10'(emax + 1 + rand_below(100));
      default: op.exp = 10'(1 + rand_below(emax - 1));
    endcase
    r    = rand_word();
    pick = rand_below(8);
    case (pick)
      0:       op.mant = {24'hff_ffff, r[3:0]};            // Rounding carries out
      1:       op.mant = '0;
      2:       op.mant = {1'b0, r[26:0]};                  // 0.1xx and smaller
      3:       op.mant = {1'b1, r[22:0], 4'b1000};         // FP32 tie
      4:       op.mant = {1'b1, r[9:0], 17'h1_0000};       // FP16 tie
      default: op.mant = {1'b1, r[26:0]};
    endcase
  endtask

  task automatic drive_cycle();
    fp_op_pkg::norm_in_t  op;
    fp_op_pkg::op_class_t cls;
    logic                 v;
    v = (rand_below(10) < 8);               // About 80% valid
    gen_item(op, cls);
    in_valid = v;
    in_op    = op;                           // Random data even when idle
    in_class = cls;
    if (v)
    begin
      expect_q.push_back(expect_item(op, cls));
      sent++;
    end
    prev_valid = v;
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial
  begin
    seed       = 43828;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_op      = '0;
    in_class   = '0;
    prev_valid = 1'b0;
    held       = '0;                         // Reset value of the outputs
    sent       = 0;
    seen       = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_equal(64'(out_valid), 64'd0, "out_valid in reset");
    check_equal(64'(out_result), 64'd0, "out_result in reset");
    check_equal(64'(out_flags), 64'd0, "out_flags in reset");
    rst_n = 1'b1;
    while (sent < N_ITEMS)
    begin
      @(negedge clk);
      compare_outputs();
      drive_cycle();
    end
    @(negedge clk);
    compare_outputs();                       // Last item
    in_valid   = 1'b0;
    prev_valid = 1'b0;
    @(negedge clk);
    compare_outputs();                       // out_valid back low
    if (seen != sent)
    begin
      $display("item count wrong: %0d sent, %0d returned", sent, seen);
      $display("ERRORS FOUND");
      $fatal(1, "output count check failed");
    end
    else
    begin
      $display("%0d items checked", seen);
      $display("NO ERRORS");
      $finish;
    end
  end

  initial
  begin
    #(LIMIT_NS);
    $display("timeout: run did not finish within %0d ns", LIMIT_NS);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verilog
verilog/fp_fmt_pkg.sv
verilog/fp_op_pkg.sv
verilog/special_case_sel.sv
verilog/mant_normalize.sv
verilog/round_pack.sv
verilog/norm_round_top.sv
verif/tb_clk_gen.sv
verif/tb_norm_round.sv

// File: Makefile
# Verilator build and run for the normalize-and-round stage
# Override any variable on the command line, e.g. make LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_norm_round
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
